// ==== all.f ====
src/boardsync_pkg.sv
src/sysref_qualifier.sv
src/timebase_counter.sv
src/coef_bank.sv
src/dsp_ctrl_out.sv
src/boardsync_top.sv
dv/boardsync_tb.sv

// ==== dv/boardsync_tb.sv ====
module boardsync_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES    = 16;
  localparam int ARM_DELAY_MAX   = 60;
  localparam int LOCK_CYCLES_MAX = 60;
  localparam int RUN_CYCLES      = 4000;
  localparam int TRIG_INTERVAL   = 400;
  // expected length plus half again as margin
  localparam int CYCLE_LIMIT =
    (RESET_CYCLES + ARM_DELAY_MAX + LOCK_CYCLES_MAX + RUN_CYCLES) * 3 / 2;

  logic                       dspclk;
  logic                       rst;
  logic                       sysref_in;
  logic                       arm;
  boardsync_pkg::clkcnt_t     corr;
  boardsync_pkg::clkcnt_src_t clkcnt_src;
  boardsync_pkg::clkcnt_t     trig;
  logic                       dsp_reset_req;
  logic                       coef_wstb;
  boardsync_pkg::coef_addr_t  coef_waddr;
  boardsync_pkg::coef_t       coef_wdata;
  logic                       coef_rstb;
  boardsync_pkg::coef_addr_t  coef_raddr;

  wire boardsync_pkg::coef_t       coef_rdata;
  wire boardsync_pkg::coef_array_t coef;
  wire                             sysref_ready;
  wire                             start;
  wire                             dsp_reset;
  wire boardsync_pkg::clkcnt_t     clkcnt_rd;
  wire boardsync_pkg::mon_t        clkcnt_mon;

  // cycle model state
  logic                   m_cur;
  logic                   m_last;
  int                     m_cnt;
  logic                   m_locked;
  boardsync_pkg::clkcnt_t m_raw;
  boardsync_pkg::clkcnt_t m_corr;
  logic                   m_hit;
  logic                   m_start;
  logic                   m_dsp_reset;
  boardsync_pkg::clkcnt_t m_rd;
  boardsync_pkg::coef_t   m_rdata;
  boardsync_pkg::coef_t   m_coef [64];

  // stimulus bookkeeping
  int          unarmed_edges;
  int          cycle_count;
  int          run_cycle;
  int          arm_on_cycle;
  int          sysref_left;
  int          sysref_low;
  logic        traffic_on;
  int unsigned seed_ret;

  boardsync_top u_dut (
    .dspclk        (dspclk),
    .rst           (rst),
    .sysref_in     (sysref_in),
    .arm           (arm),
    .corr          (corr),
    .clkcnt_src    (clkcnt_src),
    .trig          (trig),
    .dsp_reset_req (dsp_reset_req),
    .coef_wstb     (coef_wstb),
    .coef_waddr    (coef_waddr),
    .coef_wdata    (coef_wdata),
    .coef_rstb     (coef_rstb),
    .coef_raddr    (coef_raddr),
    .coef_rdata    (coef_rdata),
    .coef          (coef),
    .sysref_ready  (sysref_ready),
    .start         (start),
    .dsp_reset     (dsp_reset),
    .clkcnt_rd     (clkcnt_rd),
    .clkcnt_mon    (clkcnt_mon)
  );

  initial begin
    dspclk = 1'b0;
    forever #20 dspclk = ~dspclk;
  end

  always @(posedge dspclk) begin
    cycle_count <= cycle_count + 1;
  end

  task automatic end_with_failure();
    $display(">>> FAIL");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_clkcnt(input boardsync_pkg::clkcnt_t got,
                              input boardsync_pkg::clkcnt_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_mon(input boardsync_pkg::mon_t got,
                           input boardsync_pkg::mon_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_coef(input boardsync_pkg::coef_t got,
                            input boardsync_pkg::coef_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      end_with_failure();
    end
  endtask

  // advance the model by one dspclk edge, using the inputs seen at that edge
  task automatic model_step();
    boardsync_pkg::clkcnt_t sel;
    logic rise;
    logic full;
    sel  = (clkcnt_src == boardsync_pkg::CLKCNT_CORR) ? m_corr : m_raw;
    rise = m_cur & ~m_last;
    full = (m_cnt == boardsync_pkg::SYSREF_EDGES_NEEDED);
    m_dsp_reset = rst | dsp_reset_req;
    if (rst) begin
      m_cur    = 1'b0;
      m_last   = 1'b0;
      m_cnt    = 0;
      m_locked = 1'b0;
      m_raw    = '0;
      m_corr   = '0;
      m_hit    = 1'b0;
      m_start  = 1'b0;
      m_rd     = '0;
      m_rdata  = '0;
      foreach (m_coef[i]) m_coef[i] = '0;
    end else begin
      if (rise && !arm) unarmed_edges++;
      m_start = m_hit;
      m_hit   = (sel >= trig);
      m_rd    = sel;
      m_corr  = m_raw + corr;
      if (m_locked) m_raw = m_raw + 64'd1;
      m_locked = m_locked | full;
      if (arm && rise && !full) m_cnt++;
      m_last = m_cur;
      m_cur  = sysref_in;
      // readback sees the array before a same-cycle write
      if (coef_rstb) m_rdata = m_coef[coef_raddr];
      if (coef_wstb) m_coef[coef_waddr] = coef_wdata;
    end
  endtask

  task automatic check_outputs();
    check_bit(sysref_ready, m_locked, "sysref_ready");
    check_bit(start, m_start, "start");
    check_bit(dsp_reset, m_dsp_reset, "dsp_reset");
    check_clkcnt(clkcnt_rd, m_rd, "clkcnt_rd");
    check_mon(clkcnt_mon, boardsync_pkg::mon_t'(m_rd >> boardsync_pkg::MON_LSB),
              "clkcnt_mon");
    check_coef(coef_rdata, m_rdata, "coef_rdata");
    for (int r = 0; r < boardsync_pkg::COEF_ROWS; r++) begin
      for (int c = 0; c < boardsync_pkg::COEF_COLS; c++) begin
        check_coef(coef[r][c], m_coef[r * boardsync_pkg::COEF_COLS + c],
                   $sformatf("coef[%0d][%0d]", r, c));
      end
    end
  endtask

  // literal reset values, independent of the model
  task automatic check_reset_values(input logic exp_dsp_reset);
    check_bit(sysref_ready, 1'b0, "sysref_ready at reset");
    check_bit(start, 1'b0, "start at reset");
    check_bit(dsp_reset, exp_dsp_reset, "dsp_reset at reset");
    check_clkcnt(clkcnt_rd, '0, "clkcnt_rd at reset");
    check_mon(clkcnt_mon, '0, "clkcnt_mon at reset");
    check_coef(coef_rdata, '0, "coef_rdata at reset");
    check_bit(coef == '0, 1'b1, "coef array cleared at reset");
  endtask

  // sysref with a random period of 3 to 12 cycles
  task automatic update_sysref();
    int period;
    if (sysref_left == 0) begin
      sysref_in = ~sysref_in;
      if (sysref_in) begin
        period      = $urandom_range(3, 12);
        sysref_left = period / 2;
        sysref_low  = period - sysref_left;
      end else begin
        sysref_left = sysref_low;
      end
    end
    sysref_left--;
  endtask

  // new trigger, mostly ahead of the count and sometimes behind it
  task automatic move_trig();
    if ($urandom_range(0, 3) == 0 && m_raw > 64'd200) begin
      trig = m_raw - 64'($urandom_range(1, 200));
    end else begin
      trig = m_raw + 64'($urandom_range(200, 600));
    end
  endtask

  task automatic drive_inputs();
    update_sysref();
    if (!traffic_on) begin
      arm           = 1'b0;
      dsp_reset_req = 1'b0;
      coef_wstb     = 1'b0;
      coef_rstb     = 1'b0;
    end else begin
      run_cycle++;
      arm           = (run_cycle >= arm_on_cycle);
      dsp_reset_req = !dsp_reset_req && ($urandom_range(0, 29) == 0);
      coef_wstb     = ($urandom_range(0, 3) == 0);
      coef_waddr    = boardsync_pkg::coef_addr_t'($urandom_range(0, 63));
      coef_wdata    = $urandom;
      coef_rstb     = ($urandom_range(0, 3) == 0);
      coef_raddr    = boardsync_pkg::coef_addr_t'($urandom_range(0, 63));
      if ($urandom_range(0, 39) == 0) begin
        clkcnt_src = (clkcnt_src == boardsync_pkg::CLKCNT_RAW) ?
                     boardsync_pkg::CLKCNT_CORR : boardsync_pkg::CLKCNT_RAW;
      end
      // full width correction so every readback and monitor bit moves
      if ($urandom_range(0, 99) == 0) corr = {$urandom, $urandom};
      if (run_cycle % TRIG_INTERVAL == 0) move_trig();
    end
  endtask

  // sample shortly after the edge, drive shortly after that
  task automatic step_cycle();
    @(posedge dspclk);
    model_step();
    #1;
    check_outputs();
    #1;
    drive_inputs();
  endtask

  initial begin
    wait (cycle_count >= CYCLE_LIMIT);
    $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    end_with_failure();
  end

  initial begin
    seed_ret      = $urandom(32'ha977);
    rst           = 1'b1;
    sysref_in     = 1'b0;
    arm           = 1'b0;
    corr          = {$urandom, $urandom};
    clkcnt_src    = boardsync_pkg::CLKCNT_RAW;
    trig          = '1;
    dsp_reset_req = 1'b0;
    coef_wstb     = 1'b0;
    coef_waddr    = '0;
    coef_wdata    = '0;
    coef_rstb     = 1'b0;
    coef_raddr    = '0;
    traffic_on    = 1'b0;
    unarmed_edges = 0;
    run_cycle     = 0;
    sysref_left   = 0;
    sysref_low    = 3;
    arm_on_cycle  = $urandom_range(30, ARM_DELAY_MAX);

    for (int i = 0; i < RESET_CYCLES; i++) begin
      step_cycle();
      if (i == RESET_CYCLES - 1) rst = 1'b0;
      check_reset_values(1'b1);
    end
    step_cycle();
    check_reset_values(1'b0);
    traffic_on = 1'b1;

    // wait for the qualifier, the model checks the exact lock edge
    while (!sysref_ready) begin
      step_cycle();
    end
    if (unarmed_edges == 0) begin
      $display("no sysref edge arrived while arm was low");
      end_with_failure();
    end

    repeat (RUN_CYCLES) begin
      step_cycle();
    end

    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== src/boardsync_top.sv ====
module boardsync_top (
  input  logic                            dspclk,
  input  logic                            rst,
  input  logic                            sysref_in,
  input  logic                            arm,
  input  boardsync_pkg::clkcnt_t          corr,
  input  boardsync_pkg::clkcnt_src_t      clkcnt_src,
  input  boardsync_pkg::clkcnt_t          trig,
  input  logic                            dsp_reset_req,
  input  logic                            coef_wstb,
  input  boardsync_pkg::coef_addr_t       coef_waddr,
  input  boardsync_pkg::coef_t            coef_wdata,
  input  logic                            coef_rstb,
  input  boardsync_pkg::coef_addr_t       coef_raddr,
  output wire boardsync_pkg::coef_t       coef_rdata,
  output wire boardsync_pkg::coef_array_t coef,
  output wire                             sysref_ready,
  output wire                             start,
  output wire                             dsp_reset,
  output wire boardsync_pkg::clkcnt_t     clkcnt_rd,
  output wire boardsync_pkg::mon_t        clkcnt_mon
);

  // selected count and registered compare between the stages
  wire boardsync_pkg::clkcnt_t clkcnt;
  wire                         trig_hit;

  sysref_qualifier u_sysref (
    .dspclk       (dspclk),
    .rst          (rst),
    .sysref_in    (sysref_in),
    .arm          (arm),
    .sysref_ready (sysref_ready)
  );

  timebase_counter u_timebase (
    .dspclk       (dspclk),
    .rst          (rst),
    .sysref_ready (sysref_ready),
    .corr         (corr),
    .clkcnt_src   (clkcnt_src),
    .trig         (trig),
    .clkcnt       (clkcnt),
    .trig_hit     (trig_hit)
  );

  coef_bank u_coef (
    .dspclk     (dspclk),
    .rst        (rst),
    .coef_wstb  (coef_wstb),
    .coef_waddr (coef_waddr),
    .coef_wdata (coef_wdata),
    .coef_rstb  (coef_rstb),
    .coef_raddr (coef_raddr),
    .coef_rdata (coef_rdata),
    .coef       (coef)
  );

  dsp_ctrl_out u_ctrl (
    .dspclk        (dspclk),
    .rst           (rst),
    .trig_hit      (trig_hit),
    .clkcnt        (clkcnt),
    .dsp_reset_req (dsp_reset_req),
    .start         (start),
    .dsp_reset     (dsp_reset),
    .clkcnt_rd     (clkcnt_rd),
    .clkcnt_mon    (clkcnt_mon)
  );

endmodule

// ==== src/dsp_ctrl_out.sv ====
module dsp_ctrl_out (
  input  logic                   dspclk,
  input  logic                   rst,
  input  logic                   trig_hit,
  input  boardsync_pkg::clkcnt_t clkcnt,
  input  logic                   dsp_reset_req,
  output logic                   start,
  output logic                   dsp_reset,
  output boardsync_pkg::clkcnt_t clkcnt_rd,
  output boardsync_pkg::mon_t    clkcnt_mon
);

  // start level and counter readback
  always_ff @(posedge dspclk) begin
    if (rst) begin
      start     <= 1'b0;
      clkcnt_rd <= '0;
    end else begin
      start     <= trig_hit;
      clkcnt_rd <= clkcnt;
    end
  end

  // system reset merged with the strobed dsp request
  always_ff @(posedge dspclk) begin
    dsp_reset <= rst | dsp_reset_req;
  end

  // monitor pins take a window of the readback word
  assign clkcnt_mon = clkcnt_rd[boardsync_pkg::MON_LSB +: $bits(boardsync_pkg::mon_t)];

  a_reset_follows: assert property (
    @(posedge dspclk)
    rst |=> dsp_reset
  );

endmodule

// ==== src/coef_bank.sv ====
module coef_bank (
  input  logic                       dspclk,
  input  logic                       rst,
  input  logic                       coef_wstb,
  input  boardsync_pkg::coef_addr_t  coef_waddr,
  input  boardsync_pkg::coef_t       coef_wdata,
  input  logic                       coef_rstb,
  input  boardsync_pkg::coef_addr_t  coef_raddr,
  output boardsync_pkg::coef_t       coef_rdata,
  output boardsync_pkg::coef_array_t coef
);

  boardsync_pkg::coef_array_t coef_q;

  // read index split into row and column
  boardsync_pkg::coef_addr_t rd_row;
  boardsync_pkg::coef_addr_t rd_col;

  // one register per entry, each decoding its own flat index
  for (genvar r = 0; r < boardsync_pkg::COEF_ROWS; r++) begin : g_row
    for (genvar c = 0; c < boardsync_pkg::COEF_COLS; c++) begin : g_col
      localparam boardsync_pkg::coef_addr_t ENTRY_ADDR =
        boardsync_pkg::coef_addr_t'(r * boardsync_pkg::COEF_COLS + c);

      always_ff @(posedge dspclk) begin
        if (rst) begin
          coef_q[r][c] <= '0;
        end else if (coef_wstb && coef_waddr == ENTRY_ADDR) begin
          coef_q[r][c] <= coef_wdata;
        end
      end
    end
  end

  assign coef = coef_q;

  assign rd_row = coef_raddr / boardsync_pkg::coef_addr_t'(boardsync_pkg::COEF_COLS);
  assign rd_col = coef_raddr % boardsync_pkg::coef_addr_t'(boardsync_pkg::COEF_COLS);

  // readback holds between strobes
  always_ff @(posedge dspclk) begin
    if (rst) begin
      coef_rdata <= '0;
    end else if (coef_rstb) begin
      coef_rdata <= coef_q[rd_row][rd_col];
    end
  end

  a_waddr_known: assert property (
    @(posedge dspclk) disable iff (rst)
    coef_wstb |-> !$isunknown(coef_waddr)
  );

  a_raddr_known: assert property (
    @(posedge dspclk) disable iff (rst)
    coef_rstb |-> !$isunknown(coef_raddr)
  );

endmodule

// ==== src/timebase_counter.sv ====
module timebase_counter (
  input  logic                       dspclk,
  input  logic                       rst,
  input  logic                       sysref_ready,
  input  boardsync_pkg::clkcnt_t     corr,
  input  boardsync_pkg::clkcnt_src_t clkcnt_src,
  input  boardsync_pkg::clkcnt_t     trig,
  output boardsync_pkg::clkcnt_t     clkcnt,
  output logic                       trig_hit
);

  // free running count, only moves once sysref is qualified
  boardsync_pkg::clkcnt_t raw_cnt;

  // corrected copy, one cycle behind raw
  boardsync_pkg::clkcnt_t corr_cnt;

  always_ff @(posedge dspclk) begin
    if (rst) begin
      raw_cnt <= '0;
    end else if (sysref_ready) begin
      raw_cnt <= raw_cnt + 64'd1;
    end
  end

  always_ff @(posedge dspclk) begin
    if (rst) begin
      corr_cnt <= '0;
    end else begin
      corr_cnt <= raw_cnt + corr;
    end
  end

  // source select
  always_comb begin
    case (clkcnt_src)
      boardsync_pkg::CLKCNT_CORR: clkcnt = corr_cnt;
      default:                    clkcnt = raw_cnt;
    endcase
  end

  // trigger compare, registered
  always_ff @(posedge dspclk) begin
    if (rst) begin
      trig_hit <= 1'b0;
    end else begin
      trig_hit <= (clkcnt >= trig);
    end
  end

  // raw count is frozen until the qualifier releases it
  a_raw_hold: assert property (
    @(posedge dspclk) disable iff (rst)
    !sysref_ready |=> $stable(raw_cnt)
  );

endmodule

// ==== src/sysref_qualifier.sv ====
module sysref_qualifier (
  input  logic dspclk,
  input  logic rst,
  input  logic sysref_in,
  input  logic arm,
  output logic sysref_ready
);

  // two sampling flops on the board sysref
  logic current_sample;
  logic last_sample;

  boardsync_pkg::sysref_cnt_t   sysref_cnt;
  boardsync_pkg::sysref_state_t state;

  logic sysref_rise;
  logic cnt_full;

  always_ff @(posedge dspclk) begin
    if (rst) begin
      current_sample <= 1'b0;
      last_sample    <= 1'b0;
    end else begin
      current_sample <= sysref_in;
      last_sample    <= current_sample;
    end
  end

  assign sysref_rise = current_sample & ~last_sample;
  assign cnt_full    = (sysref_cnt ==
                        boardsync_pkg::sysref_cnt_t'(boardsync_pkg::SYSREF_EDGES_NEEDED));

  // count armed rising edges, holding at the qualify count
  always_ff @(posedge dspclk) begin
    if (rst) begin
      sysref_cnt <= '0;
    end else if (arm && sysref_rise && !cnt_full) begin
      sysref_cnt <= sysref_cnt + 1'b1;
    end
  end

  // lock one cycle after the count fills, then hold until reset
  always_ff @(posedge dspclk) begin
    if (rst) begin
      state <= boardsync_pkg::SYSREF_WAIT;
    end else if (state == boardsync_pkg::SYSREF_WAIT && cnt_full) begin
      state <= boardsync_pkg::SYSREF_LOCKED;
    end
  end

  assign sysref_ready = (state == boardsync_pkg::SYSREF_LOCKED);

  // lock is sticky while reset stays low
  a_lock_sticky: assert property (
    @(posedge dspclk) disable iff (rst)
    state == boardsync_pkg::SYSREF_LOCKED |=> state == boardsync_pkg::SYSREF_LOCKED
  );

endmodule

// ==== src/boardsync_pkg.sv ====
package boardsync_pkg;

  // cycle count, correction and trigger value
  typedef logic [63:0] clkcnt_t;

  // one coefficient word
  typedef logic [31:0] coef_t;

  // flat coefficient index, row * COEF_COLS + column
  typedef logic [5:0] coef_addr_t;

  // pin monitor slice of the cycle count
  typedef logic [13:0] mon_t;

  // armed sysref edge counter
  typedef logic [2:0] sysref_cnt_t;

  // armed edges needed before sysref counts as qualified
  localparam int SYSREF_EDGES_NEEDED = 4;

  // coefficient bank geometry
  localparam int COEF_ROWS = 8;
  localparam int COEF_COLS = 8;

  // lowest counter bit that goes out on the monitor pins
  localparam int MON_LSB = 12;

  // full coefficient array, row major
  typedef coef_t [COEF_ROWS-1:0][COEF_COLS-1:0] coef_array_t;

  typedef enum logic {
    SYSREF_WAIT,
    SYSREF_LOCKED
  } sysref_state_t;

  typedef enum logic {
    CLKCNT_RAW,
    CLKCNT_CORR
  } clkcnt_src_t;

endpackage
